/* include/stream_config.svh */
`ifndef STREAM_CONFIG_SVH
`define STREAM_CONFIG_SVH

// Number of merged input ports
`define STREAM_PORTS 4

// Payload bits carried by one beat
`define STREAM_PAYLOAD_WIDTH 16

// Port index width, log2 of the port count
`define STREAM_ID_WIDTH 2

// Configuration register map
`define CFG_ADDR_MODE 1'b0
`define CFG_ADDR_LOCK 1'b1

`endif

/* hw/stream_pkg.sv */
`default_nettype none

`include "stream_config.svh"

package stream_pkg;

    // Port index, also the width of a beat id
    typedef logic [`STREAM_ID_WIDTH-1:0] port_index_t;

    // One beat as it travels through the merge
    typedef struct packed {
        logic [`STREAM_PAYLOAD_WIDTH-1:0] payload;
        port_index_t                      id;
        logic                             last;
    } stream_beat_t;

    // Selection policy of the merge
    typedef enum logic [0:0] {
        MERGE_ROUND_ROBIN = 1'b0,
        MERGE_ORDERED     = 1'b1
    } merge_mode_t;

    // Configuration driven by the register block
    typedef struct packed {
        merge_mode_t mode;
        logic        lock_on_last;
    } merge_cfg_t;

endpackage

`default_nettype wire

/* hw/stream_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stream_config.svh"

module stream_controller (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [`STREAM_PORTS-1:0] grant,
    input  logic [`STREAM_PORTS-1:0] valid_input,
    input  logic                     ready_output,

    output logic [`STREAM_PORTS-1:0] ready_input,
    output logic [`STREAM_PORTS-1:0] consume,
    output logic                     enable
);

    logic granted_valid;
    logic any_grant;

    always_comb begin
        granted_valid = |(grant & valid_input);
        any_grant     = |grant;

        // A transfer needs the chosen source and room downstream
        enable  = granted_valid & ready_output;
        consume = grant & {`STREAM_PORTS{enable}};

        if (any_grant) begin
            ready_input = grant & {`STREAM_PORTS{ready_output}};
        end else begin
            // Idle ports see ready, valid ones waiting for their turn do not
            ready_input = ~valid_input & {`STREAM_PORTS{ready_output}};
        end
    end

endmodule

`default_nettype wire

/* hw/stream_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stream_config.svh"

module stream_stage (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     in_valid,
    input  stream_pkg::stream_beat_t in_beat,
    output logic                     in_ready,

    output logic                     out_valid,
    output stream_pkg::stream_beat_t out_beat,
    input  logic                     out_ready
);

    import stream_pkg::*;

    logic         main_valid;
    stream_beat_t main_beat;
    logic         spare_valid;
    stream_beat_t spare_beat;
    logic         accept;

    assign accept    = in_valid & in_ready;
    assign in_ready  = ~spare_valid;
    assign out_valid = main_valid;
    assign out_beat  = main_beat;

    // Valid flags
    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (out_ready || !main_valid) begin
            // Main drains, spare moves up first
            main_valid  <= spare_valid | accept;
            spare_valid <= 1'b0;
        end else if (accept) begin
            spare_valid <= 1'b1;
        end
    end

    // Beat storage
    always_ff @(posedge clk) begin
        if (out_ready || !main_valid) begin
            if (spare_valid) begin
                main_beat <= spare_beat;
            end else if (accept) begin
                main_beat <= in_beat;
            end
        end else if (accept) begin
            spare_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* hw/merge_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stream_config.svh"

module merge_arbiter (
    input  logic                     clk,
    input  logic                     rst,

    input  stream_pkg::merge_cfg_t   cfg,

    input  logic [`STREAM_PORTS-1:0] in_valid,
    input  stream_pkg::stream_beat_t in_beat [`STREAM_PORTS],

    input  logic                     enable,
    output logic [`STREAM_PORTS-1:0] grant,
    output stream_pkg::stream_beat_t sel_beat,
    output logic                     produce
);

    import stream_pkg::*;

    // Pointer in round robin, expected id in ordered mode
    port_index_t prio;
    logic        locked;

    port_index_t sel_idx;
    logic        found;

    function automatic port_index_t next_index(input port_index_t idx);
        if (int'(idx) == `STREAM_PORTS - 1) begin
            return '0;
        end
        return port_index_t'(idx + 1'b1);
    endfunction

    // Winner search
    always_comb begin
        port_index_t idx;

        found   = 1'b0;
        sel_idx = prio;
        idx     = prio;

        if (cfg.mode == MERGE_ROUND_ROBIN) begin
            if (locked) begin
                // Stay on the port until its packet ends
                found = 1'b1;
            end else begin
                for (int i = 0; i < `STREAM_PORTS; i++) begin
                    if (!found && in_valid[idx]) begin
                        found   = 1'b1;
                        sel_idx = idx;
                    end
                    idx = next_index(idx);
                end
            end
        end else begin
            // Lowest port holding the expected id
            for (int i = 0; i < `STREAM_PORTS; i++) begin
                if (!found && in_valid[i] && (in_beat[i].id == prio)) begin
                    found   = 1'b1;
                    sel_idx = port_index_t'(i);
                end
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[sel_idx] = 1'b1;
        end

        // A locked grant may sit on a port that has nothing yet
        produce = found & in_valid[sel_idx];

        sel_beat = in_beat[sel_idx];
        if (cfg.mode == MERGE_ROUND_ROBIN) begin
            sel_beat.id = sel_idx;
        end else begin
            sel_beat.id = prio;
        end
    end

    // Priority and lock state, advanced on each transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            prio   <= '0;
            locked <= 1'b0;
        end else if (enable) begin
            if (cfg.mode == MERGE_ORDERED) begin
                prio   <= next_index(prio);
                locked <= 1'b0;
            end else if (cfg.lock_on_last && !in_beat[sel_idx].last) begin
                prio   <= sel_idx;
                locked <= 1'b1;
            end else begin
                prio   <= next_index(sel_idx);
                locked <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/merge_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stream_config.svh"

module merge_cfg_regs (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   cfg_write,
    input  logic                   cfg_addr,
    input  logic                   cfg_wdata,
    output logic                   cfg_rdata,

    output stream_pkg::merge_cfg_t cfg
);

    import stream_pkg::*;

    // Round robin, no packet lock out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.mode         <= MERGE_ROUND_ROBIN;
            cfg.lock_on_last <= 1'b0;
        end else if (cfg_write) begin
            case (cfg_addr)
                `CFG_ADDR_MODE: cfg.mode         <= merge_mode_t'(cfg_wdata);
                `CFG_ADDR_LOCK: cfg.lock_on_last <= cfg_wdata;
                default: ;
            endcase
        end
    end

    // Level read of the addressed bit
    always_comb begin
        case (cfg_addr)
            `CFG_ADDR_MODE: cfg_rdata = cfg.mode;
            `CFG_ADDR_LOCK: cfg_rdata = cfg.lock_on_last;
            default:        cfg_rdata = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/stream_merge_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stream_config.svh"

module stream_merge_top (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [`STREAM_PORTS-1:0] in_valid,
    input  stream_pkg::stream_beat_t in_beat [`STREAM_PORTS],
    output logic [`STREAM_PORTS-1:0] in_ready,

    output logic                     out_valid,
    output stream_pkg::stream_beat_t out_beat,
    input  logic                     out_ready,

    input  logic                     cfg_write,
    input  logic                     cfg_addr,
    input  logic                     cfg_wdata,
    output logic                     cfg_rdata
);

    import stream_pkg::*;

    merge_cfg_t               cfg;
    logic [`STREAM_PORTS-1:0] grant;
    logic                     enable;
    stream_beat_t             sel_beat;
    logic                     produce;
    logic                     stage_ready;

    merge_cfg_regs merge_cfg_regs_inst (
        .clk, .rst,
        .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .cfg
    );

    stream_controller stream_controller_inst (
        .clk, .rst,
        .grant,
        .valid_input  (in_valid),
        .ready_output (stage_ready),
        .ready_input  (in_ready),
        .consume      (),
        .enable
    );

    merge_arbiter merge_arbiter_inst (
        .clk, .rst,
        .cfg,
        .in_valid, .in_beat,
        .enable,
        .grant, .sel_beat, .produce
    );

    // Registered output stage
    stream_stage stream_stage_inst (
        .clk, .rst,
        .in_valid  (produce),
        .in_beat   (sel_beat),
        .in_ready  (stage_ready),
        .out_valid, .out_beat, .out_ready
    );

endmodule

`default_nettype wire

/* bench/merge_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stream_config.svh"

module merge_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`STREAM_PORTS-1:0] in_valid,
    input  stream_pkg::stream_beat_t in_beat [`STREAM_PORTS],
    input  logic [`STREAM_PORTS-1:0] in_ready,
    input  logic                     out_valid,
    input  stream_pkg::stream_beat_t out_beat,
    input  logic                     out_ready,
    input  logic                     cfg_write,
    input  logic                     cfg_addr,
    input  logic                     cfg_wdata,
    input  logic                     cfg_rdata,
    output int                       pending,
    output int                       errors,
    output int                       beats_in,
    output int                       beats_out
);

    import stream_pkg::*;

    // Reference model state
    merge_mode_t  mode_m;
    logic         lock_m;
    port_index_t  prio_m;
    logic         locked_m;
    logic         was_rst;
    stream_beat_t expected_q [$];

    always @(posedge clk) begin
        logic [`STREAM_PORTS-1:0] taken;
        logic [`STREAM_PORTS-1:0] exp_grant;
        logic                     found;
        port_index_t              win;
        port_index_t              idx;
        logic                     exp_rdata;
        stream_beat_t             exp_beat;

        if (rst) begin
            mode_m    = MERGE_ROUND_ROBIN;
            lock_m    = 1'b0;
            prio_m    = '0;
            locked_m  = 1'b0;
            was_rst   = 1'b1;
            errors    = 0;
            beats_in  = 0;
            beats_out = 0;
            expected_q.delete();
        end else begin
            if (was_rst && (out_valid !== 1'b0 || in_ready !== '1)) begin
                $display("FAIL %0t: after reset expected out_valid 0 in_ready %b, got %b %b",
                         $time, {`STREAM_PORTS{1'b1}}, out_valid, in_ready);
                errors++;
            end
            was_rst = 1'b0;

            // Register read port reflects the model before any write lands
            exp_rdata = (cfg_addr == `CFG_ADDR_LOCK) ? lock_m : mode_m;
            if (cfg_rdata !== exp_rdata) begin
                $display("FAIL %0t: cfg_rdata at address %0d expected %0d, actual %0d",
                         $time, cfg_addr, exp_rdata, cfg_rdata);
                errors++;
            end

            if (out_valid && out_ready) begin
                beats_out++;
                if (expected_q.size() == 0) begin
                    $display("Output beat at %0t arrived with no accepted input behind it",
                             $time);
                    errors++;
                end else begin
                    exp_beat = expected_q.pop_front();
                    if (out_beat !== exp_beat) begin
                        // Beats shown as payload/id/last
                        $display("FAIL %0t: expected beat %h/%0d/%0d, actual %h/%0d/%0d",
                                 $time, exp_beat.payload, exp_beat.id, exp_beat.last,
                                 out_beat.payload, out_beat.id, out_beat.last);
                        errors++;
                    end
                end
            end

            taken = in_valid & in_ready;
            if (taken != '0) begin
                beats_in++;
                found = 1'b0;
                win   = prio_m;
                if (mode_m == MERGE_ROUND_ROBIN) begin
                    if (locked_m) begin
                        found = 1'b1;
                    end else begin
                        for (int k = 0; k < `STREAM_PORTS; k++) begin
                            idx = port_index_t'((int'(prio_m) + k) % `STREAM_PORTS);
                            if (!found && in_valid[idx]) begin
                                found = 1'b1;
                                win   = idx;
                            end
                        end
                    end
                end else begin
                    for (int k = 0; k < `STREAM_PORTS; k++) begin
                        idx = port_index_t'(k);
                        if (!found && in_valid[idx] && in_beat[idx].id == prio_m) begin
                            found = 1'b1;
                            win   = idx;
                        end
                    end
                end
                exp_grant      = '0;
                exp_grant[win] = found;

                if (taken !== exp_grant) begin
                    $display("FAIL %0t: accepted ports expected %b, actual %b",
                             $time, exp_grant, taken);
                    errors++;
                end else begin
                    exp_beat      = in_beat[win];
                    exp_beat.id   = (mode_m == MERGE_ROUND_ROBIN) ? win : prio_m;
                    expected_q.push_back(exp_beat);

                    if (mode_m == MERGE_ORDERED) begin
                        prio_m   = port_index_t'((int'(prio_m) + 1) % `STREAM_PORTS);
                        locked_m = 1'b0;
                    end else if (lock_m && !in_beat[win].last) begin
                        prio_m   = win;
                        locked_m = 1'b1;
                    end else begin
                        prio_m   = port_index_t'((int'(win) + 1) % `STREAM_PORTS);
                        locked_m = 1'b0;
                    end
                end
            end

            if (cfg_write) begin
                if (cfg_addr == `CFG_ADDR_MODE) begin
                    mode_m = merge_mode_t'(cfg_wdata);
                end else begin
                    lock_m = cfg_wdata;
                end
            end
        end
        pending = expected_q.size();
    end

endmodule

`default_nettype wire

/* bench/tb_stream_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stream_config.svh"

module tb_stream_merge;

    import stream_pkg::*;

    localparam int NUM_ROWS = 6;

    // One row of the stimulus table with densities in sixteenths
    typedef struct packed {
        merge_mode_t mode;
        logic        lock_on_last;
        logic [7:0]  beats;
        logic [3:0]  pkt_len;
        logic [4:0]  valid_dens;
        logic [4:0]  ready_dens;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic [`STREAM_PORTS-1:0] in_valid = '0;
    stream_beat_t             in_beat [`STREAM_PORTS] = '{default: '0};
    logic [`STREAM_PORTS-1:0] in_ready;
    logic                     out_valid;
    stream_beat_t             out_beat;
    logic                     out_ready = 1'b0;
    logic                     cfg_write;
    logic                     cfg_addr;
    logic                     cfg_wdata;
    logic                     cfg_rdata;

    int pending;
    int errors;
    int beats_in;
    int beats_out;

    row_t        rows [NUM_ROWS];
    int          total_beats = 0;
    int          limit = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h916d;

    // Current row as seen by the sources
    logic        running = 1'b0;
    logic        src_done = 1'b0;
    port_index_t row_off = '0;
    int          row_beats = 0;
    int          row_pkt = 1;
    int          row_vdens = 0;
    int          row_rdens = 16;
    int          issued [`STREAM_PORTS];

    stream_merge_top stream_merge_top_inst (
        .clk, .rst,
        .in_valid, .in_beat, .in_ready,
        .out_valid, .out_beat, .out_ready,
        .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata
    );

    merge_checker merge_checker_inst (
        .clk, .rst,
        .in_valid, .in_beat, .in_ready,
        .out_valid, .out_beat, .out_ready,
        .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .pending, .errors, .beats_in, .beats_out
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [`STREAM_PAYLOAD_WIDTH-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[`STREAM_PAYLOAD_WIDTH-2:0], lfsr[0]};
        end
    endtask

    // Port sources and output stall
    always @(posedge clk) begin
        logic [`STREAM_PORTS-1:0]        next_valid;
        logic [`STREAM_PAYLOAD_WIDTH-1:0] bits;
        logic                            all_done;
        port_index_t                     idx;

        next_valid = in_valid;
        all_done   = 1'b1;
        if (rst || !running) begin
            next_valid = '0;
            all_done   = 1'b0;
            for (int p = 0; p < `STREAM_PORTS; p++) begin
                issued[p] = 0;
            end
            out_ready <= 1'b1;
        end else begin
            for (int p = 0; p < `STREAM_PORTS; p++) begin
                idx = port_index_t'(p);
                if (next_valid[idx] && in_ready[idx]) begin
                    next_valid[idx] = 1'b0;
                end
                if (!next_valid[idx] && issued[p] < row_beats) begin
                    draw_bits(4, bits);
                    if (int'(bits[3:0]) < row_vdens) begin
                        next_valid[idx] = 1'b1;
                        draw_bits(`STREAM_PAYLOAD_WIDTH, bits);
                        in_beat[p].payload <= bits;
                        // Each port keeps one id that shifts by one per row
                        in_beat[p].id <= port_index_t'((p + int'(row_off)) % `STREAM_PORTS);
                        in_beat[p].last <= ((issued[p] + 1) % row_pkt == 0);
                        issued[p] = issued[p] + 1;
                    end
                end
                if (next_valid[idx] || issued[p] < row_beats) begin
                    all_done = 1'b0;
                end
            end
            draw_bits(4, bits);
            out_ready <= (int'(bits[3:0]) < row_rdens);
        end
        in_valid <= next_valid;
        src_done <= all_done;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the merge hung, %0d beats still pending after %0d cycles",
                     pending, cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic write_cfg(input logic addr, input logic data);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_write <= 1'b0;
    endtask

    task automatic read_back();
        @(posedge clk);
        cfg_addr <= `CFG_ADDR_MODE;
        @(posedge clk);
        cfg_addr <= `CFG_ADDR_LOCK;
        @(posedge clk);
    endtask

    task automatic wait_row_done();
        do begin
            @(negedge clk);
        end while (!(src_done && pending == 0));
    endtask

    initial begin
        rst       = 1'b1;
        cfg_write = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = 1'b0;

        // mode, lock, beats per port, packet length, valid and ready density
        rows[0] = '{MERGE_ROUND_ROBIN, 1'b0, 8'd8,  4'd1, 5'd16, 5'd16};
        rows[1] = '{MERGE_ROUND_ROBIN, 1'b1, 8'd12, 4'd4, 5'd12, 5'd10};
        rows[2] = '{MERGE_ORDERED,     1'b0, 8'd8,  4'd2, 5'd10, 5'd16};
        rows[3] = '{MERGE_ORDERED,     1'b0, 8'd12, 4'd3, 5'd7,  5'd8};
        rows[4] = '{MERGE_ROUND_ROBIN, 1'b1, 8'd8,  4'd2, 5'd16, 5'd6};
        rows[5] = '{MERGE_ROUND_ROBIN, 1'b0, 8'd16, 4'd4, 5'd9,  5'd11};
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_beats += `STREAM_PORTS * int'(rows[r].beats);
        end
        limit = total_beats * 8 + 200;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        read_back();

        for (int r = 0; r < NUM_ROWS; r++) begin
            write_cfg(`CFG_ADDR_MODE, 1'(rows[r].mode));
            write_cfg(`CFG_ADDR_LOCK, rows[r].lock_on_last);
            read_back();
            @(posedge clk);
            row_off   <= port_index_t'(r);
            row_beats <= int'(rows[r].beats);
            row_pkt   <= int'(rows[r].pkt_len);
            row_vdens <= int'(rows[r].valid_dens);
            row_rdens <= int'(rows[r].ready_dens);
            running   <= 1'b1;
            wait_row_done();
            @(posedge clk);
            running <= 1'b0;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        $display("Merge run done: %0d errors, %0d of %0d beats in, %0d beats out",
                 errors, beats_in, total_beats, beats_out);
        if (errors == 0 && beats_in == total_beats && beats_out == total_beats) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (beats_out != total_beats) begin
                $display("Beat count is off: %0d expected out of the merge, %0d seen",
                         total_beats, beats_out);
            end
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hw/stream_pkg.sv
hw/stream_controller.sv
hw/stream_stage.sv
hw/merge_arbiter.sv
hw/merge_cfg_regs.sv
hw/stream_merge_top.sv
bench/merge_checker.sv
bench/tb_stream_merge.sv

/* run.sh */
#!/bin/sh
# Build and run the stream merge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    --top-module tb_stream_merge \
    --Mdir obj_dir \
    -o sim_stream_merge \
    -f vlog.f

./obj_dir/sim_stream_merge | tee sim.log

# The run passes only if the pass line shows up in the log
grep -qx "TEST RESULT: PASS" sim.log
echo "run.sh: simulation passed"
